// ==== logic/vga_params.svh ====
// ###############################################
// vga timing and drawing constants
// ###############################################

`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// horizontal timing for 800x600 at 60 Hz, counted in pixel clocks.
`define VGA_HACTIVE     800
`define VGA_HSYNC_START 840
`define VGA_HSYNC_STOP  968
`define VGA_HTOTAL      1056

// vertical timing, counted in lines.
`define VGA_VACTIVE     600
`define VGA_VSYNC_START 601
`define VGA_VSYNC_STOP  605
`define VGA_VTOTAL      628

// rectangle size in pixels.
`define RECT_W 64
`define RECT_H 48

// rectangle position after reset.
`define RECT_X0 100
`define RECT_Y0 80

// rectangle colour as 12'hRGB, four bits per channel.
`define RECT_COLOR 12'hfd0

// constant blue level under the gradient.
`define BG_BLUE 4'h6

`endif

// ==== logic/vga_pkg.sv ====
// ###############################################
// vga shared types
// ###############################################

`default_nettype none

package vga_pkg;

  // screen coordinate, wide enough for the full line of 1056 clocks.
  typedef logic [10:0] coord_t;

  // one pixel colour, red in the top nibble.
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // state of the rectangle position register.
  // POS_IDLE takes a new position, POS_PENDING holds it until frame start.
  typedef enum logic {
    POS_IDLE,
    POS_PENDING
  } pos_state_t;

endpackage

`default_nettype wire

// ==== logic/vga_if.sv ====
// ###############################################
// vga pixel bus
// ###############################################

`timescale 1ns/100ps
`default_nettype none

interface vga_if import vga_pkg::*; ();

  coord_t hcount; // horizontal pixel position.
  coord_t vcount; // vertical line position.
  logic   hsync;
  logic   vsync;
  logic   hblnk;
  logic   vblnk;
  rgb_t   rgb;    // colour of the pixel at hcount/vcount.

  // the stage that produces the bus.
  modport src (
    output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

  // the stage that consumes the bus.
  modport snk (
    input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

endinterface

`default_nettype wire

// ==== logic/vga_timing.sv ====
// ###############################################
// vga timing generator
// ###############################################

`timescale 1ns/100ps
`default_nettype none

`include "vga_params.svh"

module vga_timing import vga_pkg::*; (
  input  logic clk,
  input  logic rst,
  vga_if.src   tim
);

  coord_t hcount_nxt;
  coord_t vcount_nxt;
  logic   hblnk_nxt;
  logic   vblnk_nxt;
  logic   hsync_nxt;
  logic   vsync_nxt;

  // the line counter advances when the pixel counter wraps.
  always_comb begin
    if (tim.hcount == coord_t'(`VGA_HTOTAL - 1)) begin
      hcount_nxt = '0;
      if (tim.vcount == coord_t'(`VGA_VTOTAL - 1)) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = coord_t'(tim.vcount + 11'd1);
      end
    end else begin
      hcount_nxt = coord_t'(tim.hcount + 11'd1);
      vcount_nxt = tim.vcount;
    end
  end

  // sync and blanking come from the next counter values.
  // That way they land in the same cycle as the counters they describe.
  always_comb begin
    hblnk_nxt = (hcount_nxt >= coord_t'(`VGA_HACTIVE));
    vblnk_nxt = (vcount_nxt >= coord_t'(`VGA_VACTIVE));
    hsync_nxt = (hcount_nxt >= coord_t'(`VGA_HSYNC_START)) &&
                (hcount_nxt <  coord_t'(`VGA_HSYNC_STOP));
    vsync_nxt = (vcount_nxt >= coord_t'(`VGA_VSYNC_START)) &&
                (vcount_nxt <  coord_t'(`VGA_VSYNC_STOP));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tim.hcount <= '0;
      tim.vcount <= '0;
      tim.hblnk  <= 1'b0;
      tim.vblnk  <= 1'b0;
      tim.hsync  <= 1'b0;
      tim.vsync  <= 1'b0;
    end else begin
      tim.hcount <= hcount_nxt;
      tim.vcount <= vcount_nxt;
      tim.hblnk  <= hblnk_nxt;
      tim.vblnk  <= vblnk_nxt;
      tim.hsync  <= hsync_nxt;
      tim.vsync  <= vsync_nxt;
    end
  end

  assign tim.rgb = '0; // the timing bus carries no picture.

  // the pixel counter never reaches the line length.
  a_hcount_range: assert property (
    @(posedge clk) disable iff (rst)
    tim.hcount < coord_t'(`VGA_HTOTAL)
  );

  // the sync pulse sits inside the horizontal blanking interval.
  a_hsync_in_blank: assert property (
    @(posedge clk) disable iff (rst)
    tim.hsync |-> tim.hblnk
  );

endmodule

`default_nettype wire

// ==== logic/draw_bg.sv ====
// ###############################################
// background painter
// ###############################################

`timescale 1ns/100ps
`default_nettype none

`include "vga_params.svh"

module draw_bg import vga_pkg::*; (
  input  logic clk,
  input  logic rst,
  vga_if.snk   in,
  vga_if.src   out
);

  localparam rgb_t WHITE = '{red: 4'hf, green: 4'hf, blue: 4'hf};

  logic border;
  logic blank;
  rgb_t rgb_nxt;

  assign blank = in.hblnk || in.vblnk;

  // outermost active row and column on each side.
  assign border = (in.hcount == '0) ||
                  (in.hcount == coord_t'(`VGA_HACTIVE - 1)) ||
                  (in.vcount == '0) ||
                  (in.vcount == coord_t'(`VGA_VACTIVE - 1));

  always_comb begin
    if (blank) begin
      rgb_nxt = '0; // nothing is driven outside the visible area.
    end else if (border) begin
      rgb_nxt = WHITE;
    end else begin
      // the gradient steps every 64 pixels in each direction.
      rgb_nxt.red   = in.hcount[9:6];
      rgb_nxt.green = in.vcount[9:6];
      rgb_nxt.blue  = `BG_BLUE;
    end
  end

  // the timing fields travel along with the colour through one stage of delay.
  always_ff @(posedge clk) begin
    if (rst) begin
      out.hcount <= '0;
      out.vcount <= '0;
      out.hsync  <= 1'b0;
      out.vsync  <= 1'b0;
      out.hblnk  <= 1'b0;
      out.vblnk  <= 1'b0;
      out.rgb    <= '0;
    end else begin
      out.hcount <= in.hcount;
      out.vcount <= in.vcount;
      out.hsync  <= in.hsync;
      out.vsync  <= in.vsync;
      out.hblnk  <= in.hblnk;
      out.vblnk  <= in.vblnk;
      out.rgb    <= rgb_nxt;
    end
  end

  // the colour stays aligned with the blanking it was computed for.
  a_black_in_blank: assert property (
    @(posedge clk) disable iff (rst)
    (out.hblnk || out.vblnk) |-> (out.rgb == '0)
  );

endmodule

`default_nettype wire

// ==== logic/draw_rect.sv ====
// ###############################################
// rectangle overlay
// ###############################################

`timescale 1ns/100ps
`default_nettype none

`include "vga_params.svh"

module draw_rect import vga_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  vga_if.snk     in,
  vga_if.src     out,
  input  logic   pos_valid,
  output logic   pos_ready,
  input  coord_t pos_x,
  input  coord_t pos_y
);

  localparam rgb_t RECT_RGB = rgb_t'(`RECT_COLOR);

  pos_state_t  state;
  coord_t      rect_x;      // position used for drawing.
  coord_t      rect_y;
  coord_t      pend_x;      // accepted position waiting for frame start.
  coord_t      pend_y;
  logic        frame_start;
  logic        pos_take;
  logic        apply;
  coord_t      cur_x;
  coord_t      cur_y;
  logic [11:0] x_end;
  logic [11:0] y_end;
  logic        hit;
  rgb_t        rgb_nxt;

  assign frame_start = (in.hcount == '0) && (in.vcount == '0);
  assign pos_take    = pos_valid && pos_ready;
  assign apply       = (state == POS_PENDING) && frame_start;

  // the first pixel of a frame already sees the new position.
  assign cur_x = apply ? pend_x : rect_x;
  assign cur_y = apply ? pend_y : rect_y;

  // one extra bit so a rectangle near the right or bottom edge does not wrap.
  assign x_end = {1'b0, cur_x} + 12'(`RECT_W);
  assign y_end = {1'b0, cur_y} + 12'(`RECT_H);

  assign hit = !in.hblnk && !in.vblnk &&
               (in.hcount >= cur_x) && ({1'b0, in.hcount} < x_end) &&
               (in.vcount >= cur_y) && ({1'b0, in.vcount} < y_end);

  assign rgb_nxt = hit ? RECT_RGB : in.rgb;

  // one accepted position is held until the frame boundary.
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= POS_IDLE;
      pos_ready <= 1'b1;
      rect_x    <= coord_t'(`RECT_X0);
      rect_y    <= coord_t'(`RECT_Y0);
    end else if (state == POS_IDLE) begin
      if (pos_take) begin
        state     <= POS_PENDING;
        pos_ready <= 1'b0;
      end
    end else if (apply) begin
      state     <= POS_IDLE;
      pos_ready <= 1'b1;
      rect_x    <= pend_x;
      rect_y    <= pend_y;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_x <= '0;
      pend_y <= '0;
    end else if (pos_take) begin
      pend_x <= pos_x;
      pend_y <= pos_y;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out.hcount <= '0;
      out.vcount <= '0;
      out.hsync  <= 1'b0;
      out.vsync  <= 1'b0;
      out.hblnk  <= 1'b0;
      out.vblnk  <= 1'b0;
      out.rgb    <= '0;
    end else begin
      out.hcount <= in.hcount;
      out.vcount <= in.vcount;
      out.hsync  <= in.hsync;
      out.vsync  <= in.vsync;
      out.hblnk  <= in.hblnk;
      out.vblnk  <= in.vblnk;
      out.rgb    <= rgb_nxt;
    end
  end

  // no new offer can be taken while one is waiting.
  a_ready_low_pending: assert property (
    @(posedge clk) disable iff (rst)
    (state == POS_PENDING) |-> !pos_ready
  );

  // the waiting position is held unchanged until it is applied.
  a_pend_stable: assert property (
    @(posedge clk) disable iff (rst)
    (state == POS_PENDING) |=> ($stable(pend_x) && $stable(pend_y))
  );

endmodule

`default_nettype wire

// ==== logic/vga_top.sv ====
// ###############################################
// vga display top level
// ###############################################

`timescale 1ns/100ps
`default_nettype none

module vga_top import vga_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       pos_valid,
  output logic       pos_ready,
  input  coord_t     pos_x,
  input  coord_t     pos_y,
  output logic       hsync,
  output logic       vsync,
  output logic [3:0] red,
  output logic [3:0] green,
  output logic [3:0] blue
);

  vga_if tim_bus ();  // counters and syncs only.
  vga_if bg_bus ();   // after the background stage.
  vga_if rect_bus (); // after the rectangle stage.

  vga_timing u_vga_timing (
    .clk (clk),
    .rst (rst),
    .tim (tim_bus)
  );

  draw_bg u_draw_bg (
    .clk (clk),
    .rst (rst),
    .in  (tim_bus),
    .out (bg_bus)
  );

  draw_rect u_draw_rect (
    .clk       (clk),
    .rst       (rst),
    .in        (bg_bus),
    .out       (rect_bus),
    .pos_valid (pos_valid),
    .pos_ready (pos_ready),
    .pos_x     (pos_x),
    .pos_y     (pos_y)
  );

  // pins are two stages behind the timing generator.
  assign hsync = rect_bus.hsync;
  assign vsync = rect_bus.vsync;
  assign red   = rect_bus.rgb.red;
  assign green = rect_bus.rgb.green;
  assign blue  = rect_bus.rgb.blue;

endmodule

`default_nettype wire

// ==== verif/vga_tb.sv ====
// ###############################################
// vga display testbench
// ###############################################

`timescale 1ns/100ps
`default_nettype none

`include "vga_params.svh"

module vga_tb import vga_pkg::*; ();

  localparam longint CLK_PERIOD   = 100;
  localparam longint FRAME_CYCLES = longint'(`VGA_HTOTAL) * `VGA_VTOTAL;
  localparam longint LIMIT_CYCLES = 4 * FRAME_CYCLES + 16 + 2000; // four frames plus slack.

  logic       clk;
  logic       rst;
  logic       pos_valid;
  logic       pos_ready;
  coord_t     pos_x;
  coord_t     pos_y;
  logic       hsync;
  logic       vsync;
  logic [3:0] red;
  logic [3:0] green;
  logic [3:0] blue;

  logic        checking;     // set once the pins show pixel (0,0).
  int          model_h;
  int          model_v;
  int          frame_num;
  int          act_x;        // rectangle position the model draws.
  int          act_y;
  logic        new_valid;    // transfer seen, not yet inside the DUT.
  int          new_x;
  int          new_y;
  logic        pend_valid;   // position waiting for the next frame start.
  int          pend_x;
  int          pend_y;
  int          accept_count;
  int          accept_frame [2];
  logic [31:0] rng_state;
  logic [13:0] exp_pixel;
  int          ax;
  int          ay;
  int          bx;
  int          by;

  vga_top dut (
    .clk       (clk),
    .rst       (rst),
    .pos_valid (pos_valid),
    .pos_ready (pos_ready),
    .pos_x     (pos_x),
    .pos_y     (pos_y),
    .hsync     (hsync),
    .vsync     (vsync),
    .red       (red),
    .green     (green),
    .blue      (blue)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // 32-bit xorshift step.
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected {hsync, vsync, red, green, blue} for one screen position.
  function automatic logic [13:0] expected_pixel(input int h, input int v,
                                                 input int rx, input int ry);
    logic        hs;
    logic        vs;
    logic [11:0] rgb;
    hs = (h >= `VGA_HSYNC_START) && (h < `VGA_HSYNC_STOP);
    vs = (v >= `VGA_VSYNC_START) && (v < `VGA_VSYNC_STOP);
    if (h >= `VGA_HACTIVE || v >= `VGA_VACTIVE) begin
      rgb = 12'h000; // blanking is always black.
    end else if (h >= rx && h < rx + `RECT_W && v >= ry && v < ry + `RECT_H) begin
      rgb = `RECT_COLOR;
    end else if (h == 0 || h == `VGA_HACTIVE - 1 || v == 0 || v == `VGA_VACTIVE - 1) begin
      rgb = 12'hfff;
    end else begin
      rgb = {4'((h >> 6) & 15), 4'((v >> 6) & 15), 4'(`BG_BLUE)};
    end
    return {hs, vs, rgb};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic wait_for_accept(input int count);
    while (accept_count < count) begin
      @(posedge clk);
    end
  endtask

  // compares the pins with the model at every falling edge.
  always @(negedge clk) begin
    if (checking) begin
      if (model_h == 0 && model_v == 0 && pend_valid) begin
        act_x      = pend_x; // frame start takes the waiting position.
        act_y      = pend_y;
        pend_valid = 1'b0;
      end
      exp_pixel = expected_pixel(model_h, model_v, act_x, act_y);
      check_value("hsync", hsync, exp_pixel[13]);
      check_value("vsync", vsync, exp_pixel[12]);
      check_value("red", red, exp_pixel[11:8]);
      check_value("green", green, exp_pixel[7:4]);
      check_value("blue", blue, exp_pixel[3:0]);
      check_value("pos_ready", pos_ready, !(pend_valid || new_valid));
      if (new_valid) begin
        pend_x     = new_x;
        pend_y     = new_y;
        pend_valid = 1'b1;
        new_valid  = 1'b0;
      end
      // a transfer happens on the next rising edge.
      if (pos_valid && pos_ready) begin
        new_x     = pos_x;
        new_y     = pos_y;
        new_valid = 1'b1;
        if (accept_count < 2) begin
          accept_frame[accept_count] = frame_num;
        end
        accept_count = accept_count + 1;
      end
      if (model_h == `VGA_HTOTAL - 1) begin
        model_h = 0;
        if (model_v == `VGA_VTOTAL - 1) begin
          model_v   = 0;
          frame_num = frame_num + 1;
        end else begin
          model_v = model_v + 1;
        end
      end else begin
        model_h = model_h + 1;
      end
    end
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout: the simulation ran past four frames without finishing");
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst          = 1'b1;
    pos_valid    = 1'b0;
    pos_x        = '0;
    pos_y        = '0;
    checking     = 1'b0;
    model_h      = 0;
    model_v      = 0;
    frame_num    = 0;
    act_x        = `RECT_X0;
    act_y        = `RECT_Y0;
    new_valid    = 1'b0;
    pend_valid   = 1'b0;
    accept_count = 0;
    rng_state    = 32'd18258;

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk); // two pipeline stages before (0,0) reaches the pins.
    checking = 1'b1;

    // first position lands fully on screen, offered in the middle of frame 0.
    rng_state = xorshift32(rng_state);
    ax = int'(rng_state % (`VGA_HACTIVE - `RECT_W));
    rng_state = xorshift32(rng_state);
    ay = int'(rng_state % (`VGA_VACTIVE - `RECT_H));
    // second position hangs over the right and bottom edges.
    rng_state = xorshift32(rng_state);
    bx = `VGA_HACTIVE - 8 - int'(rng_state % 48);
    rng_state = xorshift32(rng_state);
    by = `VGA_VACTIVE - 8 - int'(rng_state % 40);

    wait (model_v == 300);
    @(posedge clk);
    pos_valid <= 1'b1;
    pos_x     <= coord_t'(ax);
    pos_y     <= coord_t'(ay);
    wait_for_accept(1);

    // offered at once, so it has to wait out the pending one.
    pos_x <= coord_t'(bx);
    pos_y <= coord_t'(by);
    wait_for_accept(2);
    pos_valid <= 1'b0;
    check_value("second_accept_frame", accept_frame[1], accept_frame[0] + 1);

    wait (frame_num == 3);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/vga_pkg.sv
logic/vga_if.sv
logic/vga_timing.sv
logic/draw_bg.sv
logic/draw_rect.sv
logic/vga_top.sv
verif/vga_tb.sv

// ==== Bender.yml ====
package:
  name: vga_display

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/vga_pkg.sv
      - logic/vga_if.sv
      - logic/vga_timing.sv
      - logic/draw_bg.sv
      - logic/draw_rect.sv
      - logic/vga_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/vga_tb.sv
